/* design/msx_pkg.sv */
`default_nettype none

package msx_pkg;

    // Device that owns a decoded I/O port
    typedef enum logic [1:0] {
        DEV_NONE = 2'd0,
        DEV_PSG  = 2'd1,
        DEV_PPI  = 2'd2,
        DEV_TICK = 2'd3
    } io_dev_t;

    // PSG registers used by tone channel A
    typedef enum logic [3:0] {
        R_TONE_A_LO = 4'd0,
        R_TONE_A_HI = 4'd1,
        R_VOL_A     = 4'd8
    } psg_reg_t;

    // Fixed I/O port map
    localparam logic [7:0] PORT_PSG_ADDR  = 8'hA0;
    localparam logic [7:0] PORT_PSG_WDATA = 8'hA1;
    localparam logic [7:0] PORT_PSG_RDATA = 8'hA2;
    localparam logic [7:0] PORT_SLOT      = 8'hA8;
    localparam logic [7:0] PORT_KEYS      = 8'hA9;
    localparam logic [7:0] PORT_PPI_C     = 8'hAA;
    localparam logic [7:0] PORT_VDP_STAT  = 8'h99;

    localparam logic [15:0] FRAME_TICKS = 16'd2000;  // Clocks per frame interrupt

    // Audio
    localparam logic signed [15:0] KEYBEEP_LEVEL = 16'sd4096;
    localparam logic [15:0]        PSG_VOL_STEP  = 16'd256;
    localparam logic signed [15:0] SOUND_MAX     = 16'sh7FFF;
    localparam logic signed [15:0] SOUND_MIN     = 16'sh8000;

    localparam int KEY_ROWS = 11;  // Keyboard matrix rows

endpackage

`default_nettype wire

/* design/io_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface io_req_if;
    import msx_pkg::*;

    logic       req_valid;  // One-cycle strobe
    logic       req_wr;
    io_dev_t    req_dev;
    logic [7:0] req_port;
    logic [7:0] req_wdata;

    modport decoder (
        output req_valid,
        output req_wr,
        output req_dev,
        output req_port,
        output req_wdata
    );

    modport device (
        input  req_valid,
        input  req_wr,
        input  req_dev,
        input  req_port,
        input  req_wdata
    );

endinterface

`default_nettype wire

/* design/io_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module io_decoder (
    input  wire        clk_sys,
    input  wire        rst_n,
    input  wire        io_strobe,
    input  wire        io_wr,
    input  wire  [7:0] io_addr,
    input  wire  [7:0] io_wdata,
    io_req_if.decoder  req
);
    import msx_pkg::*;

    io_dev_t dev_sel;

    // Port table, the only place ports map to devices
    always_comb begin
        case (io_addr)
            PORT_PSG_ADDR,
            PORT_PSG_WDATA,
            PORT_PSG_RDATA: dev_sel = DEV_PSG;
            PORT_SLOT,
            PORT_KEYS,
            PORT_PPI_C:     dev_sel = DEV_PPI;
            PORT_VDP_STAT:  dev_sel = DEV_TICK;
            default:        dev_sel = DEV_NONE;  // Unmapped, reads FF
        endcase
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            req.req_valid <= 1'b0;
            req.req_wr    <= 1'b0;
            req.req_dev   <= DEV_NONE;
        end else begin
            req.req_valid <= io_strobe;  // Strobe delayed one cycle
            if (io_strobe) begin
                req.req_wr  <= io_wr;
                req.req_dev <= dev_sel;
            end
        end
    end

    // Payload
    always_ff @(posedge clk_sys) begin
        if (io_strobe) begin
            req.req_port  <= io_addr;
            req.req_wdata <= io_wdata;
        end
    end

endmodule

`default_nettype wire

/* design/dev_psg.sv */
`timescale 1ns/1ps
`default_nettype none

module dev_psg (
    input  wire               clk_sys,
    input  wire               rst_n,
    io_req_if.device          req,
    output logic        [7:0] rdata,
    output logic signed [15:0] psg_sound
);
    import msx_pkg::*;

    logic [7:0]  regs [16];
    logic [3:0]  psg_index;
    logic        sel;
    logic        wr_addr;
    logic        wr_data;
    logic        rd_data;
    logic [11:0] tone_period;
    logic [11:0] tone_cnt;
    logic        tone_phase;
    logic [15:0] tone_amp;

    assign sel     = req.req_valid && (req.req_dev == DEV_PSG);
    assign wr_addr = sel && req.req_wr && (req.req_port == PORT_PSG_ADDR);
    assign wr_data = sel && req.req_wr && (req.req_port == PORT_PSG_WDATA);
    assign rd_data = sel && !req.req_wr && (req.req_port == PORT_PSG_RDATA);

    assign rdata = rd_data ? regs[psg_index] : 8'hFF;

    // Index latch and register file
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            psg_index <= 4'd0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'h00;  // Silent after reset
            end
        end else begin
            if (wr_addr) begin
                psg_index <= req.req_wdata[3:0];
            end
            if (wr_data) begin
                regs[psg_index] <= req.req_wdata;
            end
        end
    end

    assign tone_period = {regs[R_TONE_A_HI][3:0], regs[R_TONE_A_LO]};

    // Tone channel A
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            tone_cnt   <= 12'd0;
            tone_phase <= 1'b0;
        end else if (tone_period == 12'd0) begin
            tone_cnt <= 12'd0;  // Phase held
        end else if (tone_cnt >= tone_period - 12'd1) begin
            tone_cnt   <= 12'd0;
            tone_phase <= ~tone_phase;
        end else begin
            tone_cnt <= tone_cnt + 12'd1;
        end
    end

    assign tone_amp = 16'(regs[R_VOL_A][3:0]) * PSG_VOL_STEP;

    // Square wave around zero
    assign psg_sound = tone_phase ? $signed(tone_amp) : -$signed(tone_amp);

endmodule

`default_nettype wire

/* design/dev_ppi.sv */
`timescale 1ns/1ps
`default_nettype none

module dev_ppi (
    input  wire                             clk_sys,
    input  wire                             rst_n,
    io_req_if.device                        req,
    input  wire [msx_pkg::KEY_ROWS*8-1:0]   key_rows,
    output logic                      [7:0] rdata,
    output logic                      [7:0] slot_config,
    output logic                            keybeep
);
    import msx_pkg::*;

    logic [7:0] port_c;
    logic [3:0] row_sel;
    logic [7:0] row_data;
    logic       sel;
    logic       wr;
    logic       rd;

    assign sel = req.req_valid && (req.req_dev == DEV_PPI);
    assign wr  = sel && req.req_wr;
    assign rd  = sel && !req.req_wr;

    assign row_sel = port_c[3:0];
    assign keybeep = port_c[7];

    // Keyboard matrix row, active low
    always_comb begin
        row_data = 8'hFF;
        if (row_sel < KEY_ROWS) begin
            row_data = key_rows[row_sel*8 +: 8];
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            slot_config <= 8'h00;
            port_c      <= 8'h00;
        end else if (wr) begin
            if (req.req_port == PORT_SLOT) begin
                slot_config <= req.req_wdata;
            end
            if (req.req_port == PORT_PPI_C) begin
                port_c <= req.req_wdata;  // Row select and beep
            end
        end
    end

    always_comb begin
        rdata = 8'hFF;
        if (rd) begin
            case (req.req_port)
                PORT_SLOT:  rdata = slot_config;
                PORT_KEYS:  rdata = row_data;
                PORT_PPI_C: rdata = port_c;
                default:    rdata = 8'hFF;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/dev_frame_tick.sv */
`timescale 1ns/1ps
`default_nettype none

module dev_frame_tick (
    input  wire        clk_sys,
    input  wire        rst_n,
    io_req_if.device   req,
    output logic [7:0] rdata,
    output logic       tick_irq
);
    import msx_pkg::*;

    logic [15:0] tick_cnt;
    logic        wrap;
    logic        stat_rd;
    logic        irq_flag;

    assign wrap    = (tick_cnt == FRAME_TICKS - 16'd1);
    assign stat_rd = req.req_valid && !req.req_wr && (req.req_dev == DEV_TICK)
                     && (req.req_port == PORT_VDP_STAT);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= 16'd0;
        end else if (wrap) begin
            tick_cnt <= 16'd0;
        end else begin
            tick_cnt <= tick_cnt + 16'd1;
        end
    end

    // Set wins over a clearing read
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            irq_flag <= 1'b0;
        end else if (wrap) begin
            irq_flag <= 1'b1;
        end else if (stat_rd) begin
            irq_flag <= 1'b0;
        end
    end

    assign rdata    = stat_rd ? {irq_flag, 7'b0} : 8'hFF;
    assign tick_irq = irq_flag;

endmodule

`default_nettype wire

/* design/io_result_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module io_result_merge (
    input  wire                clk_sys,
    input  wire                rst_n,
    input  wire                req_valid,
    input  wire                req_wr,
    input  wire          [7:0] psg_rdata,
    input  wire          [7:0] ppi_rdata,
    input  wire          [7:0] tick_rdata,
    input  wire signed  [15:0] psg_sound,
    input  wire                keybeep,
    input  wire                tick_irq,
    output logic         [7:0] io_rdata,
    output logic               io_rdata_valid,
    output logic               cpu_interrupt,
    output logic signed [15:0] sound
);
    import msx_pkg::*;

    logic signed [16:0] beep_add;
    logic signed [16:0] sound_sum;
    logic signed [15:0] sound_sat;

    assign beep_add  = keybeep ? $signed({KEYBEEP_LEVEL[15], KEYBEEP_LEVEL}) : 17'sd0;
    assign sound_sum = $signed({psg_sound[15], psg_sound}) + beep_add;

    // Clamp on overflow of the 16-bit range
    always_comb begin
        if (sound_sum > $signed({SOUND_MAX[15], SOUND_MAX})) begin
            sound_sat = SOUND_MAX;
        end else if (sound_sum < $signed({SOUND_MIN[15], SOUND_MIN})) begin
            sound_sat = SOUND_MIN;
        end else begin
            sound_sat = sound_sum[15:0];
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            io_rdata       <= 8'hFF;
            io_rdata_valid <= 1'b0;
            cpu_interrupt  <= 1'b0;
            sound          <= 16'sd0;
        end else begin
            io_rdata       <= psg_rdata & ppi_rdata & tick_rdata;  // Idle devices give FF
            io_rdata_valid <= req_valid && !req_wr;
            cpu_interrupt  <= tick_irq;  // Only interrupt source left
            sound          <= sound_sat;
        end
    end

endmodule

`default_nettype wire

/* design/msx_devices.sv */
`timescale 1ns/1ps
`default_nettype none

module msx_devices (
    input  wire                           clk_sys,
    input  wire                           rst_n,
    input  wire                           io_strobe,
    input  wire                           io_wr,
    input  wire                     [7:0] io_addr,
    input  wire                     [7:0] io_wdata,
    output logic                    [7:0] io_rdata,
    output logic                          io_rdata_valid,
    output logic                          cpu_interrupt,
    output logic signed            [15:0] sound,
    input  wire [msx_pkg::KEY_ROWS*8-1:0] key_rows,
    output logic                    [7:0] slot_config,
    output logic                          keybeep
);

    logic        [7:0] psg_rdata;
    logic        [7:0] ppi_rdata;
    logic        [7:0] tick_rdata;
    logic signed [15:0] psg_sound;
    logic              tick_irq;

    io_req_if req_bus ();

    io_decoder u_decoder (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .io_strobe (io_strobe),
        .io_wr     (io_wr),
        .io_addr   (io_addr),
        .io_wdata  (io_wdata),
        .req       (req_bus.decoder)
    );

    dev_psg u_psg (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .req       (req_bus.device),
        .rdata     (psg_rdata),
        .psg_sound (psg_sound)
    );

    dev_ppi u_ppi (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .req         (req_bus.device),
        .key_rows    (key_rows),
        .rdata       (ppi_rdata),
        .slot_config (slot_config),
        .keybeep     (keybeep)
    );

    dev_frame_tick u_tick (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .req      (req_bus.device),
        .rdata    (tick_rdata),
        .tick_irq (tick_irq)
    );

    io_result_merge u_merge (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .req_valid      (req_bus.req_valid),
        .req_wr         (req_bus.req_wr),
        .psg_rdata      (psg_rdata),
        .ppi_rdata      (ppi_rdata),
        .tick_rdata     (tick_rdata),
        .psg_sound      (psg_sound),
        .keybeep        (keybeep),
        .tick_irq       (tick_irq),
        .io_rdata       (io_rdata),
        .io_rdata_valid (io_rdata_valid),
        .cpu_interrupt  (cpu_interrupt),
        .sound          (sound)
    );

endmodule

`default_nettype wire

/* dv/tb_io_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_io_monitor (
    input wire       clk_sys,
    input wire       rst_n,
    input wire       io_strobe,
    input wire       io_wr,
    input wire [7:0] io_rdata,
    input wire       io_rdata_valid
);
    string      cur_test = "none";
    logic [7:0] exp_q[$];  // Expected read data, oldest first
    int         due_q[$];  // Edge on which each read must return
    int         edge_cnt = 0;
    int         test_cnt = 0;
    int         check_cnt = 0;
    int         err_cnt = 0;
    int         test_checks = 0;
    int         test_errs = 0;

    task automatic check(input string what, input logic [15:0] exp, input logic [15:0] act);
        test_checks++;
        check_cnt++;
        if (exp !== act) begin
            test_errs++;
            err_cnt++;
            $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
        end
    endtask

    task automatic note_error(input string msg);
        test_errs++;
        err_cnt++;
        $display("Error in test %s: %s", cur_test, msg);
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("test %s done: %0d checks, %0d errors", cur_test, test_checks, test_errs);
    endtask

    task automatic report();
        $display("totals: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    endtask

    task automatic expect_read(input logic [7:0] exp);
        exp_q.push_back(exp);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    always @(posedge clk_sys) begin : watch
        logic [7:0] exp;
        int         due;
        if (rst_n) begin
            edge_cnt++;
            if (io_strobe && !io_wr) begin
                due_q.push_back(edge_cnt + 2);  // Two-cycle read latency
            end
            if (io_rdata_valid) begin
                if (exp_q.size() == 0 || due_q.size() == 0) begin
                    note_error("read data valid with no read pending");
                end else begin
                    exp = exp_q.pop_front();
                    due = due_q.pop_front();
                    if (due != edge_cnt) begin
                        note_error("read data returned with the wrong latency");
                    end
                    check("read data", exp, io_rdata);
                end
            end else if (due_q.size() > 0 && due_q[0] <= edge_cnt) begin
                note_error("read data valid missing for a read request");
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

/* dv/msx_devices_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module msx_devices_checker (
    input wire               clk_sys,
    input wire               rst_n,
    input wire               req_valid,
    input wire               req_wr,
    input wire               io_rdata_valid,
    input wire signed [16:0] sound_sum,
    input wire signed [15:0] sound
);

    a_read_valid: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (req_valid && !req_wr) |=> io_rdata_valid)
        else $error("io_rdata_valid missing one cycle after a read request");

    a_write_quiet: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (req_valid && req_wr) |=> !io_rdata_valid)
        else $error("io_rdata_valid raised after a write request");

    // Registered sound keeps the sign of the wide sum, so it never wraps
    a_sound_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
        1'b1 |=> (!$isunknown(sound) && (sound[15] == $past(sound_sum[16]))))
        else $error("sound wrapped past the saturation bounds");

endmodule

bind io_result_merge msx_devices_checker u_checker (
    .clk_sys        (clk_sys),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_wr         (req_wr),
    .io_rdata_valid (io_rdata_valid),
    .sound_sum      (sound_sum),
    .sound          (sound)
);

`default_nettype wire

/* dv/tb_msx_devices.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_msx_devices;
    import msx_pkg::*;

    localparam int FRAME_CYCLES = 2000;  // Clocks per frame interrupt
    localparam int VOL_UNIT     = 256;
    localparam int BEEP_UNIT    = 4096;

    logic                  clk_sys = 1'b0;
    logic                  rst_n;
    logic                  io_strobe;
    logic                  io_wr;
    logic [7:0]            io_addr;
    logic [7:0]            io_wdata;
    logic [KEY_ROWS*8-1:0] key_rows;
    wire  [7:0]            io_rdata;
    wire                   io_rdata_valid;
    wire                   cpu_interrupt;
    wire  signed [15:0]    sound;
    wire  [7:0]            slot_config;
    wire                   keybeep;

    logic [7:0] psg_regs [16];  // Shadow model
    logic [3:0] psg_idx;
    logic [7:0] slot_sh;
    logic [7:0] port_c_sh;

    always #20 clk_sys = ~clk_sys;

    msx_devices UUT (.*);

    tb_io_monitor MON (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .io_strobe      (io_strobe),
        .io_wr          (io_wr),
        .io_rdata       (io_rdata),
        .io_rdata_valid (io_rdata_valid)
    );

    function automatic logic [7:0] io_expect(input logic [7:0] port);
        case (port)
            PORT_PSG_RDATA: return psg_regs[psg_idx];
            PORT_SLOT:      return slot_sh;
            PORT_KEYS:      return (port_c_sh[3:0] < KEY_ROWS) ?
                                   key_rows[port_c_sh[3:0]*8 +: 8] : 8'hFF;
            PORT_PPI_C:     return port_c_sh;
            default:        return 8'hFF;  // Unmapped or write-only
        endcase
    endfunction

    function automatic logic [15:0] sound_expect(input int vol, input bit phase, input bit beep);
        int level;
        level = phase ? vol * VOL_UNIT : -vol * VOL_UNIT;
        if (beep) level += BEEP_UNIT;
        if (level > 32767) level = 32767;
        if (level < -32768) level = -32768;
        return level[15:0];
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic issue(input bit wr, input logic [7:0] port, input logic [7:0] data);
        io_strobe = 1'b1;
        io_wr     = wr;
        io_addr   = port;
        io_wdata  = data;
        @(negedge clk_sys);
        io_strobe = 1'b0;
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        case (port)
            PORT_PSG_ADDR:  psg_idx = data[3:0];
            PORT_PSG_WDATA: psg_regs[psg_idx] = data;
            PORT_SLOT:      slot_sh = data;
            PORT_PPI_C:     port_c_sh = data;
            default: ;
        endcase
        issue(1'b1, port, data);
    endtask

    task automatic io_read(input logic [7:0] port, input logic [7:0] exp);
        MON.expect_read(exp);
        issue(1'b0, port, 8'h00);
    endtask

    task automatic set_psg(input logic [3:0] idx, input logic [7:0] val);
        io_write(PORT_PSG_ADDR, {4'h0, idx});
        io_write(PORT_PSG_WDATA, val);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (MON.pending() != 0 && n < 10) begin
            @(negedge clk_sys);
            n++;
        end
        if (MON.pending() != 0) MON.note_error("read responses still pending after timeout");
    endtask

    task automatic tone_check(input int vol, input bit beep);
        logic [15:0] hi_val;
        logic [15:0] lo_val;
        bit          seen_hi;
        bit          seen_lo;
        int          n;
        hi_val  = sound_expect(vol, 1'b1, beep);
        lo_val  = sound_expect(vol, 1'b0, beep);
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        n       = 0;
        while (!(seen_hi && seen_lo) && n < 200) begin
            @(negedge clk_sys);
            MON.check("sound level", (sound === lo_val) ? lo_val : hi_val, sound);
            seen_hi |= (sound === hi_val);
            seen_lo |= (sound === lo_val);
            n++;
        end
        if (!(seen_hi && seen_lo)) MON.note_error("sound did not reach both tone levels");
    endtask

    initial begin
        int         vol;
        int         n;
        logic [3:0] row;
        void'($urandom(90));
        rst_n     = 1'b0;
        io_strobe = 1'b0;
        io_wr     = 1'b0;
        io_addr   = 8'h00;
        io_wdata  = 8'h00;
        key_rows  = '1;
        psg_idx   = 4'h0;
        slot_sh   = 8'h00;
        port_c_sh = 8'h00;
        for (int i = 0; i < 16; i++) psg_regs[i] = 8'h00;
        repeat (16) @(negedge clk_sys);
        rst_n = 1'b1;
        @(negedge clk_sys);

        MON.begin_test("reset");
        MON.check("io_rdata_valid", 16'h0, io_rdata_valid);
        MON.check("cpu_interrupt", 16'h0, cpu_interrupt);
        MON.check("keybeep", 16'h0, keybeep);
        MON.check("slot_config", 16'h0, slot_config);
        MON.check("io_rdata", 16'hFF, io_rdata);
        io_read(8'h55, io_expect(8'h55));
        wait_idle();
        MON.end_test();

        MON.begin_test("psg_regs");
        repeat (12) begin
            io_write(PORT_PSG_ADDR, 8'($urandom_range(15, 0)));
            io_write(PORT_PSG_WDATA, 8'($urandom));
            io_read(PORT_PSG_RDATA, io_expect(PORT_PSG_RDATA));  // Cycle right after the write
        end
        for (int i = 0; i < 16; i++) begin
            io_write(PORT_PSG_ADDR, 8'(i));
            io_read(PORT_PSG_RDATA, io_expect(PORT_PSG_RDATA));
        end
        wait_idle();
        MON.end_test();

        MON.begin_test("ppi");
        io_write(PORT_SLOT, 8'($urandom));
        io_read(PORT_SLOT, io_expect(PORT_SLOT));
        wait_idle();
        MON.check("slot_config", slot_sh, slot_config);
        for (int i = 0; i < 10; i++) begin
            for (int r = 0; r < KEY_ROWS; r++) key_rows[r*8 +: 8] = 8'($urandom);
            row = (i < 2) ? 4'(11 + 3 * i) : 4'($urandom_range(15, 0));  // Rows past the matrix
            io_write(PORT_PPI_C, {4'h0, row});
            io_read(PORT_KEYS, io_expect(PORT_KEYS));
            io_read(PORT_PPI_C, io_expect(PORT_PPI_C));
            wait_idle();
        end
        MON.end_test();

        MON.begin_test("sound");
        vol = $urandom_range(14, 1);
        io_write(PORT_PPI_C, 8'h00);
        set_psg(R_TONE_A_LO, 8'($urandom_range(8, 2)));
        set_psg(R_TONE_A_HI, 8'h00);
        set_psg(R_VOL_A, 8'(vol));
        repeat (4) @(negedge clk_sys);
        tone_check(vol, 1'b0);
        io_write(PORT_PPI_C, 8'h80);
        repeat (4) @(negedge clk_sys);
        MON.check("keybeep", 16'h1, keybeep);
        tone_check(vol, 1'b1);
        set_psg(R_VOL_A, 8'h0F);
        repeat (4) @(negedge clk_sys);
        tone_check(15, 1'b1);
        MON.end_test();

        MON.begin_test("frame_irq");
        n = 0;
        while (!cpu_interrupt && n < FRAME_CYCLES + 50) begin
            @(negedge clk_sys);
            n++;
        end
        if (!cpu_interrupt) MON.note_error("cpu_interrupt did not rise within a frame");
        io_read(PORT_VDP_STAT, 8'h80);
        io_read(PORT_VDP_STAT, 8'h00);  // Flag already cleared
        n = 0;
        while (cpu_interrupt && n < 10) begin
            @(negedge clk_sys);
            n++;
        end
        if (cpu_interrupt) MON.note_error("cpu_interrupt did not fall after the status read");
        wait_idle();
        MON.end_test();

        MON.report();
        if (MON.err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* msx_devices.f */
design/msx_pkg.sv
design/io_req_if.sv
design/io_decoder.sv
design/dev_psg.sv
design/dev_ppi.sv
design/dev_frame_tick.sv
design/io_result_merge.sv
design/msx_devices.sv
dv/tb_io_monitor.sv
dv/msx_devices_checker.sv
dv/tb_msx_devices.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the msx_devices testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f msx_devices.f \
    --top-module tb_msx_devices \
    -o sim_msx_devices

./obj_dir/sim_msx_devices | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
